/* logic/qpsk_backend_pkg.sv */
//////////////////////////////
// Shared constants and types for the QPSK symbol back end
// Every RTL module imports this package with a wildcard import
// Holds the sign pair, dibit and beat structs, and the frame word union
//////////////////////////////
`default_nettype none

package qpsk_backend_pkg;

	// Four possible byte alignments, one per dibit slot in a byte
	localparam int NUM_CUTS = 4;
	// Cut checker confidence counter, saturates at all ones
	localparam int FC_BITS = 6;
	localparam int SAMPLE_BITS = 7;
	localparam int PWM_BITS = 8;

	// Descrambler history and its taps, position 1 is the newest bit
	localparam int SCRAM_LEN = 31;
	localparam int SCRAM_TAP_NEAR = 13;
	localparam int SCRAM_TAP_FAR = 31;

	// Cut selected before any lock
	localparam logic [1:0] FRAME_POS_RESET = 2'd3;

	// Sign bits of one carrier-corrected constellation point
	typedef struct packed {
		logic i_neg;
		logic q_neg;
	} sym_signs_t;

	// One differentially decoded symbol
	typedef struct packed {
		logic hi;
		logic lo;
	} dibit_t;

	// Decoded symbol plus its position modulo 4 and a valid strobe
	typedef struct packed {
		logic ce;
		logic [1:0] count;
		dibit_t bits;
	} dibit_beat_t;

	// Filled as four dibits, newest in slot 0, read as marker plus sample
	typedef union packed {
		dibit_t [NUM_CUTS-1:0] dibits;
		struct packed {
			logic marker;
			logic [SAMPLE_BITS-1:0] sample;
		} fields;
	} frame_word_t;

endpackage

`default_nettype wire

/* logic/diff_decoder.sv */
//////////////////////////////
// Differential QPSK decoder
// Takes the sign pair of each new symbol and emits a dibit beat
// from the phase step against the previous symbol, one cycle later
//////////////////////////////
`default_nettype none

module diff_decoder
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_sym_ce,
	input wire sym_signs_t i_sym,
	output dibit_beat_t o_beat
);

	sym_signs_t prev_sym;
	logic [1:0] dibit_cnt;
	logic [1:0] ring_step;
	dibit_t step_dibit;
	logic beat_ce;
	logic [1:0] beat_count;
	dibit_t beat_bits;

	// Position of a sign pair on the ring 00, 01, 11, 10
	function automatic logic [1:0] ring_pos(input sym_signs_t s);
		return {s.i_neg, s.i_neg ^ s.q_neg};
	endfunction

	// Forward steps from the previous point, modulo 4
	assign ring_step = ring_pos(i_sym) - ring_pos(prev_sym);

	// Phase step to dibit
	always_comb
	begin
		case (ring_step)
			2'd0: step_dibit = '{hi: 1'b0, lo: 1'b0};
			2'd1: step_dibit = '{hi: 1'b0, lo: 1'b1};
			2'd2: step_dibit = '{hi: 1'b1, lo: 1'b1};
			default: step_dibit = '{hi: 1'b1, lo: 1'b0};
		endcase
	end

	// Control state: strobe, reference point and dibit position
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			beat_ce <= 1'b0;
			prev_sym <= '0;
			dibit_cnt <= '0;
		end
		else
		begin
			beat_ce <= i_sym_ce;
			if (i_sym_ce)
			begin
				prev_sym <= i_sym;
				dibit_cnt <= dibit_cnt + 2'd1;
			end
		end
	end

	// Beat payload, count is the position of this dibit
	always_ff @(posedge i_clk)
	begin
		if (i_sym_ce)
		begin
			beat_bits <= step_dibit;
			beat_count <= dibit_cnt;
		end
	end

	assign o_beat = '{ce: beat_ce, count: beat_count, bits: beat_bits};

endmodule

`default_nettype wire

/* logic/frame_cut_checker.sv */
//////////////////////////////
// Frame marker checker for one byte alignment
// Looks at the dibit in its own slot of every byte and
// flags a match once the marker has held long enough
//////////////////////////////
`default_nettype none

module frame_cut_checker
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire dibit_beat_t i_beat,
	input wire [1:0] i_cut_index,
	output logic o_match
);

	logic [FC_BITS-1:0] conf;
	logic my_slot;
	logic marker_ok;

	// Only the dibit that would carry the marker under this cut counts
	assign my_slot = i_beat.ce && (i_beat.count == i_cut_index);
	// Marker dibit has its two bits different
	assign marker_ok = i_beat.bits.hi ^ i_beat.bits.lo;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			conf <= '0;
			o_match <= 1'b0;
		end
		else if (my_slot)
		begin
			if (marker_ok)
			begin
				// Match only after the counter saturates
				if (&conf)
					o_match <= 1'b1;
				else
					conf <= conf + 1'b1;
			end
			else
			begin
				// One bad marker drops the match at once
				o_match <= 1'b0;
				if (conf != '0)
					conf <= conf - 1'b1;
			end
		end
	end

	// Counter saturates at both ends and never wraps around
	a_conf_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		((conf == '1) || (conf == '0)) |=> (conf != ~$past(conf)));

endmodule

`default_nettype wire

/* logic/frame_aligner.sv */
//////////////////////////////
// Frame aligner
// Picks the cut from the checker match vector, shifts dibits into
// a byte and emits the 7-bit scrambled sample once per frame
//////////////////////////////
`default_nettype none

module frame_aligner
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire dibit_beat_t i_beat,
	input wire [NUM_CUTS-1:0] i_cut_match,
	output logic o_frame_ce,
	output logic [SAMPLE_BITS-1:0] o_frame_sample,
	output logic o_locked,
	output logic [1:0] o_frame_pos
);

	frame_word_t frame_sreg;
	logic [1:0] match_idx;
	logic match_onehot;
	logic emit;
	logic emit_last_beat;

	//////////////////////////////
	// Cut selection
	//////////////////////////////

	// Index of the matching cut, valid when the vector is one-hot
	always_comb
	begin
		match_idx = '0;
		for (int k = 0; k < NUM_CUTS; k++)
		begin
			if (i_cut_match[k])
				match_idx = k[1:0];
		end
	end

	assign match_onehot = (i_cut_match != '0)
		&& ((i_cut_match & (i_cut_match - 1'b1)) == '0);
	// Locked when exactly one cut matches
	assign o_locked = match_onehot;

	// Frame boundary compares against the position before this beat's update
	assign emit = i_beat.ce && (i_beat.count == o_frame_pos);

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			o_frame_pos <= FRAME_POS_RESET;
			o_frame_ce <= 1'b0;
			emit_last_beat <= 1'b0;
		end
		else
		begin
			o_frame_ce <= emit;
			if (i_beat.ce)
			begin
				emit_last_beat <= emit;
				// No clean lock, hold the old cut
				if (match_onehot)
					o_frame_pos <= match_idx;
			end
		end
	end

	//////////////////////////////
	// Byte assembly
	//////////////////////////////

	// Sample leaves before the new dibit, which starts the next byte
	always_ff @(posedge i_clk)
	begin
		if (emit)
			o_frame_sample <= frame_sreg.fields.sample;
		if (i_beat.ce)
			frame_sreg.dibits <= {frame_sreg.dibits[NUM_CUTS-2:0], i_beat.bits};
	end

	// A frame never ends on two back to back dibits
	a_no_adjacent_frames: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_beat.ce && emit_last_beat) |=> !o_frame_ce);

endmodule

`default_nettype wire

/* logic/descrambler.sv */
//////////////////////////////
// Self-synchronizing descrambler
// Each frame strobe descrambles seven bits, MSB first, against
// a 31-bit history of received bits with taps at 13 and 31
//////////////////////////////
`default_nettype none

module descrambler
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_frame_ce,
	input wire [SAMPLE_BITS-1:0] i_frame_sample,
	output logic o_audio_ce,
	output logic signed [SAMPLE_BITS-1:0] o_audio_sample
);

	logic [SCRAM_LEN-1:0] hist;
	logic [SCRAM_LEN-1:0] hist_next;
	logic [SAMPLE_BITS-1:0] plain;

	// Bit serial unrolled over one sample
	// hist[0] holds position 1, the most recent received bit
	always_comb
	begin
		hist_next = hist;
		for (int b = SAMPLE_BITS - 1; b >= 0; b--)
		begin
			plain[b] = i_frame_sample[b] ^ hist_next[SCRAM_TAP_NEAR-1]
				^ hist_next[SCRAM_TAP_FAR-1];
			// Received bit, not the output, feeds the history
			hist_next = {hist_next[SCRAM_LEN-2:0], i_frame_sample[b]};
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			hist <= '0;
			o_audio_ce <= 1'b0;
		end
		else
		begin
			o_audio_ce <= i_frame_ce;
			if (i_frame_ce)
				hist <= hist_next;
		end
	end

	// Audio sample register
	always_ff @(posedge i_clk)
	begin
		if (i_frame_ce)
			o_audio_sample <= plain;
	end

	// Audio strobe lags the aligner's frame strobe by exactly one clock
	a_audio_ce_lag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_audio_ce == $past(i_frame_ce));

endmodule

`default_nettype wire

/* logic/sigma_delta_pwm.sv */
//////////////////////////////
// First-order sigma-delta audio output
// Runs every clock on the last audio sample
// Disabled audio gives a plain square wave on the pin
//////////////////////////////
`default_nettype none

module sigma_delta_pwm
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_audio_en,
	input wire [SAMPLE_BITS-1:0] i_sample,
	output logic o_pwm_audio
);

	logic [PWM_BITS-1:0] acc;
	logic [PWM_BITS-1:0] sample_ext;
	logic [PWM_BITS-1:0] bias;

	// Two's complement sample, sign extended
	assign sample_ext = {{(PWM_BITS-SAMPLE_BITS){i_sample[SAMPLE_BITS-1]}}, i_sample};
	// Adds 64 while the top bit is clear
	assign bias = {1'b0, ~acc[PWM_BITS-1], {(PWM_BITS-2){1'b0}}};

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			acc <= '0;
			o_pwm_audio <= 1'b0;
		end
		else if (i_audio_en)
		begin
			acc <= acc + sample_ext + bias;
			o_pwm_audio <= acc[PWM_BITS-1];
		end
		else
		begin
			// Mute, toggle the output for a mid-level average
			acc <= '0;
			o_pwm_audio <= ~o_pwm_audio;
		end
	end

endmodule

`default_nettype wire

/* logic/qpsk_backend.sv */
//////////////////////////////
// QPSK receiver symbol back end, top level
// Input is the sign pair of each carrier-corrected symbol
// Output is the descrambled audio sample and a one-bit audio stream
//////////////////////////////
`default_nettype none

module qpsk_backend
	import qpsk_backend_pkg::*;
(
	input wire i_clk,
	input wire i_rst_n,
	input wire i_sym_ce,
	input wire sym_signs_t i_sym,
	input wire i_audio_en,
	output logic o_audio_ce,
	output logic signed [SAMPLE_BITS-1:0] o_audio_sample,
	output logic o_locked,
	output logic [1:0] o_frame_pos,
	output logic o_pwm_audio
);

	dibit_beat_t beat;
	logic [NUM_CUTS-1:0] cut_match;
	logic frame_ce;
	logic [SAMPLE_BITS-1:0] frame_sample;

	// Phase difference decode
	diff_decoder u_diff_decoder (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_sym_ce(i_sym_ce),
		.i_sym(i_sym),
		.o_beat(beat)
	);

	//////////////////////////////
	// One checker per byte alignment
	//////////////////////////////
	for (genvar k = 0; k < NUM_CUTS; k++)
	begin : g_cut
		frame_cut_checker u_checker (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_beat(beat),
			.i_cut_index(2'(k)),
			.o_match(cut_match[k])
		);
	end

	frame_aligner u_frame_aligner (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_beat(beat),
		.i_cut_match(cut_match),
		.o_frame_ce(frame_ce),
		.o_frame_sample(frame_sample),
		.o_locked(o_locked),
		.o_frame_pos(o_frame_pos)
	);

	descrambler u_descrambler (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_frame_ce(frame_ce),
		.i_frame_sample(frame_sample),
		.o_audio_ce(o_audio_ce),
		.o_audio_sample(o_audio_sample)
	);

	// Audio pin is driven from the held sample
	sigma_delta_pwm u_sigma_delta_pwm (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_audio_en(i_audio_en),
		.i_sample(o_audio_sample),
		.o_pwm_audio(o_pwm_audio)
	);

endmodule

`default_nettype wire

/* sim/tb_qpsk_backend.sv */
//////////////////////////////
// Testbench for the QPSK symbol back end
// Drives framed and unframed random symbols into dut0 and checks
// every output against a cycle model of the back end each clock
//////////////////////////////
`default_nettype none

module tb_qpsk_backend;
	import qpsk_backend_pkg::*;

	// Cycle budget of each test, five cycles per symbol covers the longest gap
	localparam int ACQ_FRAMES = 120;
	localparam int REC_FRAMES = 60;
	localparam int AUD_FRAMES = 20;
	localparam int MUTE_CYCLES = 40;
	localparam int NOISE_SYMS = 200;
	localparam int TEST_CYCLES = 10 + (4 + ACQ_FRAMES * 4) * 5 + REC_FRAMES * 20
		+ AUD_FRAMES * 20 + MUTE_CYCLES + NOISE_SYMS * 5;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic i_clk = 1'b0;
	logic i_rst_n;
	logic i_sym_ce;
	sym_signs_t i_sym;
	logic i_audio_en;
	logic o_audio_ce;
	logic signed [SAMPLE_BITS-1:0] o_audio_sample;
	logic o_locked;
	logic [1:0] o_frame_pos;
	logic o_pwm_audio;

	qpsk_backend dut0 (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_sym_ce(i_sym_ce),
		.i_sym(i_sym),
		.i_audio_en(i_audio_en),
		.o_audio_ce(o_audio_ce),
		.o_audio_sample(o_audio_sample),
		.o_locked(o_locked),
		.o_frame_pos(o_frame_pos),
		.o_pwm_audio(o_pwm_audio)
	);

	always #10 i_clk = ~i_clk;

	logic [31:0] lfsr = 32'h0c2b_c1d5;
	int errors = 0;
	int test_errors0 = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	logic [30:0] tx_hist = '0;
	logic [1:0] tx_ring = '0;
	logic [6:0] last_src;
	logic have_src = 1'b0;
	// Expected source sample travels three clocks behind its symbol strobe
	logic [7:0] pend = '0;
	logic [7:0] dly0 = '0;
	logic [7:0] dly1 = '0;
	logic [7:0] dly2 = '0;
	logic framed = 1'b0;
	int post_lock = 0;
	int recovered = 0;
	logic mute_check = 1'b0;
	logic pwm_prev;

	// Model state
	logic [1:0] m_prev;
	logic [1:0] m_cnt;
	logic m_beat_ce;
	logic [1:0] m_beat_cnt;
	logic [1:0] m_beat_bits;
	logic [5:0] m_conf [4];
	logic [3:0] m_match;
	logic [1:0] m_pos;
	logic m_frame_ce;
	logic [6:0] m_frame_sample;
	logic [7:0] m_sreg;
	logic [30:0] m_hist;
	logic m_audio_ce;
	logic [6:0] m_audio_sample;
	logic [7:0] m_acc;
	logic m_pwm;
	logic m_locked;

	// Locked while exactly one cut matches
	assign m_locked = ($countones(m_match) == 1);

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] get_bits(input int n);
		logic fb;
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Ring 00 01 11 10, sign pair to position and back
	function automatic logic [1:0] ring_of(input logic [1:0] s);
		case (s)
			2'b00: return 2'd0;
			2'b01: return 2'd1;
			2'b11: return 2'd2;
			default: return 2'd3;
		endcase
	endfunction

	function automatic logic [1:0] signs_of(input logic [1:0] p);
		return {p[1], p[1] ^ p[0]};
	endfunction

	// Steps 0 1 2 3 give dibits 00 01 11 10
	function automatic logic [1:0] dibit_of_step(input logic [1:0] st);
		case (st)
			2'd0: return 2'b00;
			2'd1: return 2'b01;
			2'd2: return 2'b11;
			default: return 2'b10;
		endcase
	endfunction

	// Returns new history above the seven plain bits
	function automatic logic [37:0] descramble(input logic [30:0] h, input logic [6:0] s);
		logic [6:0] p;
		for (int b = 6; b >= 0; b--)
		begin
			p[b] = s[b] ^ h[12] ^ h[30];
			h = {h[29:0], s[b]};
		end
		return {h, p};
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	always @(posedge i_clk)
	begin : model
		logic [37:0] d;
		logic [1:0] idx;
		logic emit;
		cycles <= cycles + 1;
		dly0 <= pend;
		dly1 <= dly0;
		dly2 <= dly1;
		if (!i_rst_n)
		begin
			m_prev <= '0;
			m_cnt <= '0;
			m_beat_ce <= 1'b0;
			m_match <= '0;
			for (int c = 0; c < 4; c++)
				m_conf[c] <= '0;
			m_pos <= 2'd3;
			m_frame_ce <= 1'b0;
			m_hist <= '0;
			m_audio_ce <= 1'b0;
			m_acc <= '0;
			m_pwm <= 1'b0;
		end
		else
		begin
			m_beat_ce <= i_sym_ce;
			if (i_sym_ce)
			begin
				m_beat_bits <= dibit_of_step(ring_of(i_sym) - m_prev);
				m_beat_cnt <= m_cnt;
				m_prev <= ring_of(i_sym);
				m_cnt <= m_cnt + 2'd1;
			end
			for (int c = 0; c < 4; c++)
			begin
				if (m_beat_ce && m_beat_cnt == 2'(c))
				begin
					if (m_beat_bits[1] != m_beat_bits[0])
					begin
						if (m_conf[c] == 6'd63)
							m_match[c] <= 1'b1;
						else
							m_conf[c] <= m_conf[c] + 6'd1;
					end
					else
					begin
						m_match[c] <= 1'b0;
						if (m_conf[c] != 0)
							m_conf[c] <= m_conf[c] - 6'd1;
					end
				end
			end
			idx = m_match[1] ? 2'd1 : m_match[2] ? 2'd2 : m_match[3] ? 2'd3 : 2'd0;
			emit = m_beat_ce && (m_beat_cnt == m_pos);
			m_frame_ce <= emit;
			if (m_beat_ce)
			begin
				if (m_locked)
					m_pos <= idx;
				m_sreg <= {m_sreg[5:0], m_beat_bits};
			end
			if (emit)
				m_frame_sample <= m_sreg[6:0];
			m_audio_ce <= m_frame_ce;
			if (m_frame_ce)
			begin
				d = descramble(m_hist, m_frame_sample);
				m_hist <= d[37:7];
				m_audio_sample <= d[6:0];
			end
			// Sigma-delta runs on the sample that the DUT holds
			if (i_audio_en)
			begin
				m_acc <= m_acc + {o_audio_sample[6], o_audio_sample}
					+ (m_acc[7] ? 8'd0 : 8'd64);
				m_pwm <= m_acc[7];
			end
			else
			begin
				m_acc <= '0;
				m_pwm <= ~m_pwm;
			end
		end
	end

	//////////////////////////////
	// Checks, sampled on the falling edge
	//////////////////////////////
	always @(negedge i_clk)
	begin
		if (i_rst_n)
		begin
			assert (o_audio_ce == m_audio_ce)
			else
			begin
				$display("mismatch at %0t: o_audio_ce dut=%0b model=%0b", $time,
					o_audio_ce, m_audio_ce);
				errors++;
			end
			assert (o_locked == m_locked)
			else
			begin
				$display("mismatch at %0t: o_locked dut=%0b model=%0b", $time,
					o_locked, m_locked);
				errors++;
			end
			assert (o_frame_pos == m_pos)
			else
			begin
				$display("mismatch at %0t: o_frame_pos dut=%0d model=%0d", $time,
					o_frame_pos, m_pos);
				errors++;
			end
			assert (o_pwm_audio === m_pwm)
			else
			begin
				$display("mismatch at %0t: o_pwm_audio dut=%0b model=%0b", $time,
					o_pwm_audio, m_pwm);
				errors++;
			end
			if (m_audio_ce)
			begin
				// Bits from the unfilled first byte stay unknown until flushed
				assert (o_audio_sample === m_audio_sample)
				else
				begin
					$display("mismatch at %0t: o_audio_sample dut=%0h model=%0h", $time,
						o_audio_sample, m_audio_sample);
					errors++;
				end
				// Enough history after lock, the source sample comes out
				if (framed && m_locked && post_lock > 5)
				begin
					assert (dly2[7] && o_audio_sample == dly2[6:0])
					else
					begin
						$display("mismatch at %0t: o_audio_sample dut=%0h source=%0h",
							$time, o_audio_sample, dly2[6:0]);
						errors++;
					end
					recovered++;
				end
				post_lock = (framed && m_locked) ? post_lock + 1 : 0;
			end
			if (mute_check)
			begin
				assert (o_pwm_audio != pwm_prev)
				else
				begin
					$display("at %0t the muted audio output did not toggle", $time);
					errors++;
				end
			end
			pwm_prev = o_pwm_audio;
		end
	end

	always @(posedge i_clk)
	begin
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, the run did not complete", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// One symbol after a random gap, first marks a byte start
	task automatic send_dibit(input logic [1:0] d, input logic first);
		logic [31:0] gap;
		gap = get_bits(2);
		repeat (gap)
		begin
			@(negedge i_clk);
			i_sym_ce = 1'b0;
			pend = '0;
		end
		@(negedge i_clk);
		tx_ring = tx_ring + {d[1], d[1] ^ d[0]};
		i_sym = signs_of(tx_ring);
		i_sym_ce = 1'b1;
		pend = (first && have_src) ? {1'b1, last_src} : 8'h00;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge i_clk);
			i_sym_ce = 1'b0;
			pend = '0;
		end
	endtask

	task automatic send_frames(input int n);
		logic [31:0] r;
		logic [6:0] t;
		logic [7:0] byte_v;
		for (int f = 0; f < n; f++)
		begin
			r = get_bits(7);
			for (int b = 6; b >= 0; b--)
			begin
				t[b] = r[b] ^ tx_hist[12] ^ tx_hist[30];
				tx_hist = {tx_hist[29:0], t[b]};
			end
			byte_v = {~t[6], t};
			for (int k = 0; k < 4; k++)
				send_dibit(byte_v[7-2*k -: 2], k == 0);
			last_src = r[6:0];
			have_src = 1'b1;
		end
	endtask

	task automatic send_noise(input int n);
		logic [31:0] r;
		have_src = 1'b0;
		for (int k = 0; k < n; k++)
		begin
			r = get_bits(2);
			send_dibit(r[1:0], 1'b0);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_errors0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_errors0);
		end
		test_errors0 = errors;
	endtask

	initial
	begin : main
		logic [31:0] off;
		logic [1:0] held_pos;
		i_rst_n = 1'b0;
		i_sym_ce = 1'b0;
		i_sym = '0;
		i_audio_en = 1'b0;
		repeat (5) @(negedge i_clk);
		assert (!o_audio_ce && !o_locked && !o_pwm_audio && o_frame_pos == 2'd3)
		else
		begin
			$display("the outputs are not in their reset state during reset");
			errors++;
		end
		i_rst_n = 1'b1;
		end_test("reset state");

		// Random dibit offset before the first frame, the marker lands on that cut
		off = get_bits(2);
		send_noise(off);
		framed = 1'b1;
		send_frames(ACQ_FRAMES);
		idle(4);
		assert (o_locked && m_locked && o_frame_pos == off[1:0])
		else
		begin
			$display("the receiver did not lock on the cut of the framed symbols");
			errors++;
		end
		end_test("acquisition");

		i_audio_en = 1'b1;
		send_frames(REC_FRAMES);
		idle(4);
		assert (recovered > 0)
		else
		begin
			$display("no source sample was recovered after lock");
			errors++;
		end
		end_test("sample recovery");

		send_frames(AUD_FRAMES);
		idle(2);
		i_audio_en = 1'b0;
		idle(1);
		mute_check = 1'b1;
		idle(MUTE_CYCLES);
		mute_check = 1'b0;
		end_test("audio output");

		framed = 1'b0;
		held_pos = o_frame_pos;
		send_noise(NOISE_SYMS);
		idle(4);
		assert (!o_locked && o_frame_pos == held_pos)
		else
		begin
			$display("the lock did not drop or the frame position moved on noise");
			errors++;
		end
		end_test("loss of lock");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* qpsk_backend.f */
logic/qpsk_backend_pkg.sv
logic/diff_decoder.sv
logic/frame_cut_checker.sv
logic/frame_aligner.sv
logic/descrambler.sv
logic/sigma_delta_pwm.sv
logic/qpsk_backend.sv
sim/tb_qpsk_backend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the back end testbench with Verilator, then grep the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f qpsk_backend.f --top-module tb_qpsk_backend \
	-o sim_qpsk_backend > build.log 2>&1 \
	&& ./obj_dir/sim_qpsk_backend > sim.log 2>&1 \
	; cat build.log sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
